//--- scope_pkg.sv
/*
 * Shared definitions of the capture engine: field widths, register map,
 * and the packed structs passed between the control and datapath blocks
 */
package scope_pkg;

    // Sample, tag and stored word widths
    localparam int SAMPLE_WIDTH = 16;
    localparam int CHANNEL_WIDTH = 8;
    localparam int WORD_WIDTH = 32;

    // Configuration field widths
    localparam int FRAME_WIDTH = 16;
    localparam int ADDR_WIDTH = 32;
    localparam int TRIGGER_SEL_WIDTH = 8;

    // Register port address width and register offsets
    localparam int REG_ADDR_WIDTH = 3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_FRAME_LENGTH = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_ENABLE = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BASE_ADDR = 3'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRIGGER = 3'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE_ACK = 3'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRIGGER_POSITION = 3'd5;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 3'd6;

    // One register write, a single strobe with address and data
    typedef struct packed {
        logic                      strobe;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0]     data;
    } reg_write_t;

    // Stored configuration, shared by every datapath block
    typedef struct packed {
        logic [FRAME_WIDTH-1:0]       frame_length;
        logic                         enable;
        logic [ADDR_WIDTH-1:0]        base_addr;
        logic [TRIGGER_SEL_WIDTH-1:0] selected_trigger;
        logic [FRAME_WIDTH-1:0]       trigger_position;
    } scope_cfg_t;

    // Word stream beat, the word holds channel, zero byte and sample
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [WORD_WIDTH-1:0] word;
    } tagged_word_t;

    // Single cycle memory write that is always accepted
    typedef struct packed {
        logic                  strobe;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
    } mem_write_t;

endpackage

//--- scope_regs.sv
/*
 * Control register bank: write decode into the stored configuration,
 * trigger and acknowledge pulses, and the combinational read mux
 */
`timescale 1ns/1ns

module scope_regs (
    input  logic                                clock,
    input  logic                                rst,
    input  scope_pkg::reg_write_t               reg_write,
    input  logic [scope_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr,
    input  logic                                capture_inhibit,
    output logic [scope_pkg::WORD_WIDTH-1:0]    reg_read_data,
    output scope_pkg::scope_cfg_t               cfg,
    output logic                                trigger_pulse,
    output logic                                capture_ack
);

    // Each field lands one cycle after the strobe, pulses last one cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            cfg <= '0;
            trigger_pulse <= 1'b0;
            capture_ack <= 1'b0;
        end else begin
            trigger_pulse <= 1'b0;
            capture_ack <= 1'b0;
            if (reg_write.strobe) begin
                case (reg_write.addr)
                    scope_pkg::REG_FRAME_LENGTH: begin
                        cfg.frame_length <= reg_write.data[scope_pkg::FRAME_WIDTH-1:0];
                    end
                    scope_pkg::REG_ENABLE: begin
                        cfg.enable <= reg_write.data[0];
                    end
                    scope_pkg::REG_BASE_ADDR: begin
                        cfg.base_addr <= reg_write.data[scope_pkg::ADDR_WIDTH-1:0];
                    end
                    scope_pkg::REG_TRIGGER: begin
                        // The selection and its pulse become visible together
                        cfg.selected_trigger <=
                            reg_write.data[scope_pkg::TRIGGER_SEL_WIDTH-1:0];
                        trigger_pulse <= 1'b1;
                    end
                    scope_pkg::REG_CAPTURE_ACK: begin
                        capture_ack <= 1'b1;
                    end
                    scope_pkg::REG_TRIGGER_POSITION: begin
                        cfg.trigger_position <= reg_write.data[scope_pkg::FRAME_WIDTH-1:0];
                    end
                    default: begin
                        // Status is read only and unmapped offsets are ignored
                    end
                endcase
            end
        end
    end

    // Reads are zero extended, the acknowledge offset always reads zero
    always_comb begin
        reg_read_data = '0;
        case (reg_read_addr)
            scope_pkg::REG_FRAME_LENGTH:
                reg_read_data[scope_pkg::FRAME_WIDTH-1:0] = cfg.frame_length;
            scope_pkg::REG_ENABLE:
                reg_read_data[0] = cfg.enable;
            scope_pkg::REG_BASE_ADDR:
                reg_read_data[scope_pkg::ADDR_WIDTH-1:0] = cfg.base_addr;
            scope_pkg::REG_TRIGGER:
                reg_read_data[scope_pkg::TRIGGER_SEL_WIDTH-1:0] = cfg.selected_trigger;
            scope_pkg::REG_TRIGGER_POSITION:
                reg_read_data[scope_pkg::FRAME_WIDTH-1:0] = cfg.trigger_position;
            scope_pkg::REG_STATUS:
                reg_read_data[0] = capture_inhibit;  // live freeze level
            default:
                reg_read_data = '0;
        endcase
    end

endmodule

//--- stream_combiner.sv
/*
 * Channel combiner: one pending sample per channel, merged lowest index
 * first into a single stream of channel tagged words
 */
`timescale 1ns/1ns

module stream_combiner #(
    parameter int N_STREAMS = 6
) (
    input  logic                                           clock,
    input  logic                                           rst,
    input  logic [N_STREAMS-1:0]                           stream_valid,
    input  logic [N_STREAMS-1:0][scope_pkg::SAMPLE_WIDTH-1:0] stream_data,
    output scope_pkg::tagged_word_t                        combined
);

    logic [N_STREAMS-1:0]                              pending;
    logic [N_STREAMS-1:0][scope_pkg::SAMPLE_WIDTH-1:0] held;
    logic [N_STREAMS-1:0]                              grant;
    logic [N_STREAMS-1:0]                              load;
    logic [scope_pkg::CHANNEL_WIDTH-1:0]               sel;
    logic [scope_pkg::SAMPLE_WIDTH-1:0]                sample;

    // Scanning from the top down leaves the lowest pending channel selected
    always_comb begin
        grant = '0;
        sel = '0;
        sample = '0;
        for (int i = N_STREAMS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                grant = '0;
                grant[i] = 1'b1;
                sel = i[scope_pkg::CHANNEL_WIDTH-1:0];
                sample = held[i];
            end
        end
    end

    // A channel emitted this cycle is free again and may take a new sample
    assign load = stream_valid & ~(pending & ~grant);

    always_ff @(posedge clock) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~grant) | load;
        end
    end

    // Held samples only matter while their pending flag is set
    always_ff @(posedge clock) begin
        for (int i = 0; i < N_STREAMS; i++) begin
            if (load[i]) begin
                held[i] <= stream_data[i];
            end
        end
    end

    // Tag in the top byte, a zero byte, then the sample
    assign combined.valid = |pending;
    assign combined.last = 1'b0;
    assign combined.word = {sel,
        {(scope_pkg::WORD_WIDTH - scope_pkg::CHANNEL_WIDTH - scope_pkg::SAMPLE_WIDTH){1'b0}},
        sample};

endmodule

//--- capture_framer.sv
/*
 * Frame cutter: counts accepted words, marks the last word of each frame
 * and drops words while capture is disabled or frozen
 */
`timescale 1ns/1ns

module capture_framer (
    input  logic                               clock,
    input  logic                               rst,
    input  scope_pkg::scope_cfg_t              cfg,
    input  logic                               capture_inhibit,
    input  scope_pkg::tagged_word_t            data_in,
    output scope_pkg::tagged_word_t            data_out,
    output logic [scope_pkg::FRAME_WIDTH-1:0]  frame_position
);

    logic [scope_pkg::FRAME_WIDTH-1:0] count;
    logic                              accept;
    logic                              at_last;
    logic                              valid_q;
    logic                              last_q;
    logic [scope_pkg::WORD_WIDTH-1:0]  word_q;

    // Dropped words leave the count untouched, so a cut frame resumes later
    assign accept = data_in.valid && cfg.enable && !capture_inhibit;
    assign at_last = (count == cfg.frame_length - 1'b1);

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            valid_q <= accept;
            last_q <= accept && at_last;
            if (accept) begin
                // Wrap after the last word so the next frame starts at zero
                count <= at_last ? '0 : count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            word_q <= data_in.word;
        end
    end

    assign data_out = '{valid: valid_q, last: last_q, word: word_q};

    // Words already stored in the frame, used by the trigger arming test
    assign frame_position = count;

endmodule

//--- trigger_hub.sv
/*
 * Trigger hub: registered one-hot software trigger output and the
 * arm, freeze and acknowledge state of the capture
 */
`timescale 1ns/1ns

module trigger_hub #(
    parameter int N_TRIGGERS = 16
) (
    input  logic                              clock,
    input  logic                              rst,
    input  scope_pkg::scope_cfg_t             cfg,
    input  logic                              trigger_pulse,
    input  logic                              capture_ack,
    input  scope_pkg::tagged_word_t           framed,
    input  logic [scope_pkg::FRAME_WIDTH-1:0] frame_position,
    output logic                              capture_inhibit,
    output logic [N_TRIGGERS-1:0]             trigger_out
);

    logic [N_TRIGGERS-1:0] onehot;
    logic                  armed;

    // A selection at or past N_TRIGGERS matches no line and drives nothing
    always_comb begin
        onehot = '0;
        for (int i = 0; i < N_TRIGGERS; i++) begin
            if (cfg.selected_trigger == i[scope_pkg::TRIGGER_SEL_WIDTH-1:0]) begin
                onehot[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            trigger_out <= '0;
            armed <= 1'b0;
            capture_inhibit <= 1'b0;
        end else begin
            // The line is high for the single cycle after the pulse
            trigger_out <= trigger_pulse ? onehot : '0;

            if (capture_ack) begin
                armed <= 1'b0;
                capture_inhibit <= 1'b0;
            end else begin
                // Arm only once enough pre-trigger words are in the frame
                if (trigger_pulse && (frame_position >= cfg.trigger_position)) begin
                    armed <= 1'b1;
                end
                // Freeze when the armed frame has been completely written
                if (armed && framed.valid && framed.last) begin
                    capture_inhibit <= 1'b1;
                end
            end
        end
    end

endmodule

//--- dma_writer.sv
/*
 * Memory writer: turns framed words into word aligned writes from the base
 * address and pulses done with the write of each last word
 */
`timescale 1ns/1ns

module dma_writer (
    input  logic                    clock,
    input  logic                    rst,
    input  scope_pkg::scope_cfg_t   cfg,
    input  scope_pkg::tagged_word_t framed,
    output scope_pkg::mem_write_t   mem_write,
    output logic                    dma_done
);

    logic [scope_pkg::FRAME_WIDTH-1:0] offset;
    logic [scope_pkg::ADDR_WIDTH-1:0]  byte_offset;
    logic                              strobe_q;
    logic                              done_q;
    logic [scope_pkg::ADDR_WIDTH-1:0]  addr_q;
    logic [scope_pkg::WORD_WIDTH-1:0]  data_q;

    // Word offset scaled to bytes, four bytes per stored word
    always_comb begin
        byte_offset = '0;
        byte_offset[scope_pkg::FRAME_WIDTH+1:2] = offset;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            offset <= '0;
            strobe_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            strobe_q <= framed.valid;
            done_q <= framed.valid && framed.last;
            if (framed.valid) begin
                // Every frame overwrites the same buffer from its start
                offset <= framed.last ? '0 : offset + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (framed.valid) begin
            addr_q <= cfg.base_addr + byte_offset;
            data_q <= framed.word;
        end
    end

    assign mem_write = '{strobe: strobe_q, addr: addr_q, data: data_q};

    // Done rides along with the write of the last word
    assign dma_done = done_q;

endmodule

//--- scope_dma.sv
/*
 * Top level of the capture engine: register bank, channel combiner,
 * framer, trigger hub and memory writer
 */
`timescale 1ns/1ns

module scope_dma #(
    parameter int N_STREAMS = 6,
    parameter int N_TRIGGERS = 16
) (
    input  logic                                              clock,
    input  logic                                              rst,
    input  logic [N_STREAMS-1:0]                              stream_valid,
    input  logic [N_STREAMS-1:0][scope_pkg::SAMPLE_WIDTH-1:0] stream_data,
    input  scope_pkg::reg_write_t                             reg_write,
    input  logic [scope_pkg::REG_ADDR_WIDTH-1:0]              reg_read_addr,
    output logic [scope_pkg::WORD_WIDTH-1:0]                  reg_read_data,
    output scope_pkg::mem_write_t                             mem_write,
    output logic                                              dma_done,
    output logic [N_TRIGGERS-1:0]                             trigger_out
);

    scope_pkg::scope_cfg_t             cfg;
    scope_pkg::tagged_word_t           combined;
    scope_pkg::tagged_word_t           framed;
    logic [scope_pkg::FRAME_WIDTH-1:0] frame_position;
    logic                              trigger_pulse;
    logic                              capture_ack;
    logic                              capture_inhibit;

    // The only control block, everything else reads its configuration
    scope_regs i_regs (
        .clock           (clock),
        .rst             (rst),
        .reg_write       (reg_write),
        .reg_read_addr   (reg_read_addr),
        .capture_inhibit (capture_inhibit),
        .reg_read_data   (reg_read_data),
        .cfg             (cfg),
        .trigger_pulse   (trigger_pulse),
        .capture_ack     (capture_ack)
    );

    stream_combiner #(
        .N_STREAMS (N_STREAMS)
    ) i_combiner (
        .clock        (clock),
        .rst          (rst),
        .stream_valid (stream_valid),
        .stream_data  (stream_data),
        .combined     (combined)
    );

    // The freeze from the hub feeds back into the framer
    capture_framer i_framer (
        .clock           (clock),
        .rst             (rst),
        .cfg             (cfg),
        .capture_inhibit (capture_inhibit),
        .data_in         (combined),
        .data_out        (framed),
        .frame_position  (frame_position)
    );

    trigger_hub #(
        .N_TRIGGERS (N_TRIGGERS)
    ) i_triggers (
        .clock           (clock),
        .rst             (rst),
        .cfg             (cfg),
        .trigger_pulse   (trigger_pulse),
        .capture_ack     (capture_ack),
        .framed          (framed),
        .frame_position  (frame_position),
        .capture_inhibit (capture_inhibit),
        .trigger_out     (trigger_out)
    );

    dma_writer i_writer (
        .clock     (clock),
        .rst       (rst),
        .cfg       (cfg),
        .framed    (framed),
        .mem_write (mem_write),
        .dma_done  (dma_done)
    );

endmodule

//--- tb_clock.sv
/*
 * Testbench clock and reset source, 4 ns period, reset held for 5 cycles
 */
`timescale 1ns/1ns

module tb_clock (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

//--- tb_scope_dma.sv
/*
 * Testbench of the capture engine: stimulus table, reference model of the
 * framing and freeze rules, memory write monitor and watchdog
 */
`timescale 1ns/1ns

module tb_scope_dma;

    localparam int N_STREAMS = 6;
    localparam int N_TRIGGERS = 16;
    localparam int N_ROWS = 5;
    localparam int CYCLE_NS = 4;

    // One row of the stimulus table where the trigger is written before burst trigger_after
    typedef struct {
        string       name;
        logic [15:0] frame_length;
        logic [31:0] base_addr;
        logic [7:0]  selected_trigger;
        logic [15:0] trigger_position;
        int          bursts;
        int          trigger_after;
        logic        enable;
    } test_row_t;

    // One memory write with the done level seen in the same cycle
    typedef struct packed {
        logic        done;
        logic [31:0] addr;
        logic [31:0] data;
    } write_rec_t;

    logic                       clock;
    logic                       rst;
    logic [N_STREAMS-1:0]       stream_valid;
    logic [N_STREAMS-1:0][15:0] stream_data;
    scope_pkg::reg_write_t      reg_write;
    logic [2:0]                 reg_read_addr;
    logic [31:0]                reg_read_data;
    scope_pkg::mem_write_t      mem_write;
    logic                       dma_done;
    logic [N_TRIGGERS-1:0]      trigger_out;

    test_row_t  rows [N_ROWS];
    write_rec_t seen [$];
    write_rec_t expected [$];
    logic       table_ready;
    string      current_test;
    int         row_errors;
    int         total_errors;
    int         failed_tests;

    // The reference state holds the words in the current frame, the armed trigger and the freeze
    logic [15:0] model_pos;
    logic        model_armed;
    logic        model_inhibit;

    tb_clock i_clock (
        .clock (clock),
        .rst   (rst)
    );

    scope_dma #(
        .N_STREAMS  (N_STREAMS),
        .N_TRIGGERS (N_TRIGGERS)
    ) i_dut (
        .clock         (clock),
        .rst           (rst),
        .stream_valid  (stream_valid),
        .stream_data   (stream_data),
        .reg_write     (reg_write),
        .reg_read_addr (reg_read_addr),
        .reg_read_data (reg_read_data),
        .mem_write     (mem_write),
        .dma_done      (dma_done),
        .trigger_out   (trigger_out)
    );

    // The memory side is sampled mid cycle where the registered outputs are stable
    always @(negedge clock) begin
        if (!rst && (mem_write.strobe || dma_done)) begin
            seen.push_back('{done: dma_done, addr: mem_write.addr, data: mem_write.data});
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp_value,
                               input logic [31:0] act_value);
        assert (exp_value === act_value) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     current_test, what, exp_value, act_value);
            row_errors++;
        end
    endtask

    // Strobe is held for one clock, then released on the next falling edge
    task automatic write_register(input logic [2:0] addr, input logic [31:0] data);
        reg_write = '{strobe: 1'b1, addr: addr, data: data};
        @(negedge clock);
        reg_write = '0;
    endtask

    task automatic check_register(input string what, input logic [2:0] addr,
                                  input logic [31:0] exp_value);
        reg_read_addr = addr;
        @(negedge clock);
        check_value(what, exp_value, reg_read_data);
    endtask

    // The line must show up exactly in the second cycle after the strobe
    task automatic fire_trigger(input int r);
        logic [N_TRIGGERS-1:0] onehot;
        onehot = {{(N_TRIGGERS-1){1'b0}}, 1'b1} << rows[r].selected_trigger;
        write_register(scope_pkg::REG_TRIGGER, {24'h0, rows[r].selected_trigger});
        check_value("trigger_out one cycle after the write", 32'h0, 32'(trigger_out));
        @(negedge clock);
        check_value("trigger_out two cycles after the write", 32'(onehot), 32'(trigger_out));
        @(negedge clock);
        check_value("trigger_out three cycles after the write", 32'h0, 32'(trigger_out));
        // Capture arms only once the frame holds the pre-trigger words
        if (model_pos >= rows[r].trigger_position) begin
            model_armed = 1'b1;
        end
        check_register("selected trigger", scope_pkg::REG_TRIGGER,
                       {24'h0, rows[r].selected_trigger});
    endtask

    // All six channels strobe at once and the expected words follow channel order 0 to 5
    task automatic run_burst(input int r);
        logic [31:0] rnd;
        logic [15:0] sample;
        logic        is_last;
        for (int ch = 0; ch < N_STREAMS; ch++) begin
            rnd = $urandom();
            sample = rnd[15:0];
            stream_data[3'(ch)] = sample;
            if (rows[r].enable && !model_inhibit) begin
                is_last = (model_pos == rows[r].frame_length - 16'd1);
                expected.push_back('{done: is_last,
                                     addr: rows[r].base_addr + {14'h0, model_pos, 2'b00},
                                     data: {8'(ch), 8'h00, sample}});
                model_pos = is_last ? 16'd0 : model_pos + 16'd1;
                // An armed capture freezes once its frame is complete
                if (is_last && model_armed) begin
                    model_inhibit = 1'b1;
                end
            end
        end
        stream_valid = '1;
        @(negedge clock);
        stream_valid = '0;
        repeat (6) @(negedge clock);
    endtask

    task automatic check_writes();
        int waited;
        int n;
        waited = 0;
        repeat (2) @(negedge clock);
        while (seen.size() < expected.size() && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        assert (seen.size() >= expected.size()) else begin
            $display("Error in %s: memory writes stopped before all expected words arrived",
                     current_test);
            row_errors++;
        end
        check_value("write count", 32'(expected.size()), 32'(seen.size()));
        n = (seen.size() < expected.size()) ? seen.size() : expected.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("address of write %0d", i), expected[i].addr, seen[i].addr);
            check_value($sformatf("data of write %0d", i), expected[i].data, seen[i].data);
            check_value($sformatf("dma_done with write %0d", i),
                        32'(expected[i].done), 32'(seen[i].done));
        end
        seen.delete();
        expected.delete();
    endtask

    task automatic run_row(input int r);
        current_test = rows[r].name;
        row_errors = 0;
        seen.delete();
        expected.delete();
        write_register(scope_pkg::REG_FRAME_LENGTH, {16'h0, rows[r].frame_length});
        write_register(scope_pkg::REG_BASE_ADDR, rows[r].base_addr);
        write_register(scope_pkg::REG_TRIGGER_POSITION, {16'h0, rows[r].trigger_position});
        write_register(scope_pkg::REG_ENABLE, {31'h0, rows[r].enable});
        check_register("frame length", scope_pkg::REG_FRAME_LENGTH,
                       {16'h0, rows[r].frame_length});
        check_register("base address", scope_pkg::REG_BASE_ADDR, rows[r].base_addr);
        check_register("trigger position", scope_pkg::REG_TRIGGER_POSITION,
                       {16'h0, rows[r].trigger_position});
        check_register("enable", scope_pkg::REG_ENABLE, {31'h0, rows[r].enable});
        check_register("acknowledge register", scope_pkg::REG_CAPTURE_ACK, 32'h0);
        check_register("status", scope_pkg::REG_STATUS, 32'h0);
        for (int b = 0; b < rows[r].bursts; b++) begin
            if (b == rows[r].trigger_after) begin
                fire_trigger(r);
            end
            run_burst(r);
        end
        check_writes();
        // A frozen capture holds until acknowledged, then refills from the base
        if (model_inhibit) begin
            check_register("status while frozen", scope_pkg::REG_STATUS, 32'h1);
            // The data bits are all set, yet the acknowledge offset must still read zero
            write_register(scope_pkg::REG_CAPTURE_ACK, 32'hffff_ffff);
            model_inhibit = 1'b0;
            model_armed = 1'b0;
            check_register("status after acknowledge", scope_pkg::REG_STATUS, 32'h0);
            do begin
                run_burst(r);
            end while (model_pos != 16'd0);
            check_writes();
        end
        if (row_errors == 0) begin
            $display("Test %s: pass", current_test);
        end else begin
            $display("Test %s: failed with %0d errors", current_test, row_errors);
            failed_tests++;
        end
        total_errors += row_errors;
    endtask

    // The watchdog allows 12 cycles per burst plus 200 cycles per row
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            limit_ns += longint'(rows[r].bursts * 12 + 200);
        end
        limit_ns = limit_ns * CYCLE_NS;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        stream_valid = '0;
        stream_data = '0;
        reg_write = '0;
        reg_read_addr = '0;
        table_ready = 1'b0;
        total_errors = 0;
        failed_tests = 0;
        model_pos = '0;
        model_armed = 1'b0;
        model_inhibit = 1'b0;
        void'($urandom(95));
        // Frame lengths are multiples of six so every frame ends on a burst boundary
        rows[0] = '{"merge_frames", 16'd12, 32'h0000_1000, 8'd3, 16'hffff, 4, 0, 1'b1};
        rows[1] = '{"short_frames", 16'd6, 32'h2000_0040, 8'd15, 16'hffff, 3, 0, 1'b1};
        rows[2] = '{"no_trigger_line", 16'd18, 32'h0000_0080, 8'd20, 16'hffff, 3, 0, 1'b1};
        rows[3] = '{"freeze_and_ack", 16'd12, 32'h0000_3000, 8'd0, 16'd3, 4, 1, 1'b1};
        rows[4] = '{"disabled", 16'd12, 32'h0000_4000, 8'd7, 16'hffff, 2, 0, 1'b0};
        table_ready = 1'b1;
        @(negedge clock);
        while (rst) begin
            @(negedge clock);
        end
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("Ran %0d tests, %0d failed, %0d check errors",
                 N_ROWS, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- scope_dma.f
scope_pkg.sv
scope_regs.sv
stream_combiner.sv
capture_framer.sv
trigger_hub.sv
dma_writer.sv
scope_dma.sv
tb_clock.sv
tb_scope_dma.sv

//--- run.sh
#!/bin/sh
# Builds the capture engine with its testbench in Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scope_dma \
    -f scope_dma.f -o sim_scope_dma
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_scope_dma)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
